// File: hdl/lsq_defines.svh
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// number of queue slots, power of two
`define LSQ_DEPTH 8

// commit tag width
`define LSQ_TAG_W 6

// byte address and data widths
`define LSQ_ADDR_W 32
`define LSQ_DATA_W 32

// byte offset bits inside one 8-byte word
`define LSQ_OFS_W 3

`endif

// File: hdl/lsq_pkg.sv
`include "lsq_defines.svh"

package lsq_pkg;

    localparam int SLOT_W = $clog2(`LSQ_DEPTH);

    typedef logic [SLOT_W-1:0] lsq_slot_t;
    // extra msb is the wrap bit
    typedef logic [SLOT_W:0] lsq_ptr_t;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } lsq_size_t;

    // word number plus byte offset
    typedef struct packed {
        logic [`LSQ_ADDR_W-`LSQ_OFS_W-1:0] word;
        logic [`LSQ_OFS_W-1:0]             ofs;
    } lsq_word_addr_t;

    // raw view for memory and exact match, split view for overlap
    typedef union packed {
        logic [`LSQ_ADDR_W-1:0] raw;
        lsq_word_addr_t         split;
    } lsq_addr_u;

    typedef struct packed {
        logic                   busy;
        logic                   is_load;
        logic [`LSQ_TAG_W-1:0]  tag;
        logic                   addr_known;
        lsq_addr_u              addr;
        lsq_size_t              size;
        logic [`LSQ_DATA_W-1:0] data;
        logic                   retired;
        logic                   mem_sent;
        logic                   done;
        logic                   comp_sent;
    } lsq_entry_t;

    typedef enum logic [1:0] {
        FWD_WAIT,
        FWD_FORWARD,
        FWD_TO_MEMORY,
        FWD_BLOCKED
    } lsq_fwd_e;

endpackage

// File: hdl/lsq_sel_if.sv
`timescale 1ns/1ps
`include "lsq_defines.svh"

interface lsq_sel_if;
    import lsq_pkg::*;

    // load read accepted by memory
    logic                   mem_fire;
    lsq_slot_t              mem_slot;
    // read data returned
    logic                   rsp_fire;
    lsq_slot_t              rsp_slot;
    logic [`LSQ_DATA_W-1:0] rsp_data;
    // completion handshake
    logic                   comp_fire;
    lsq_slot_t              comp_slot;
    // head store write accepted
    logic                   drain_fire;

    modport issue (
        output mem_fire, mem_slot,
        output rsp_fire, rsp_slot, rsp_data,
        output comp_fire, comp_slot,
        output drain_fire
    );

    modport queue (
        input mem_fire, mem_slot,
        input rsp_fire, rsp_slot, rsp_data,
        input comp_fire, comp_slot,
        input drain_fire
    );

endinterface

// File: hdl/lsq_queue.sv
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_queue (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   disp_valid,
    input  logic                   disp_is_load,
    input  logic [`LSQ_TAG_W-1:0]  disp_tag,
    input  logic                   fill_valid,
    input  lsq_pkg::lsq_slot_t     fill_slot,
    input  lsq_pkg::lsq_addr_u     fill_addr,
    input  lsq_pkg::lsq_size_t     fill_size,
    input  logic [`LSQ_DATA_W-1:0] fill_data,
    input  logic                   commit_valid,
    input  logic [`LSQ_TAG_W-1:0]  commit_tag,
    lsq_sel_if.queue               sel,
    output logic                   disp_ready,
    output lsq_pkg::lsq_slot_t     disp_slot,
    output lsq_pkg::lsq_entry_t    entries [`LSQ_DEPTH],
    output lsq_pkg::lsq_ptr_t      head
);
    import lsq_pkg::*;

    lsq_ptr_t   tail;
    lsq_slot_t  head_slot;
    lsq_slot_t  tail_slot;
    logic       full;
    logic       do_disp;
    logic       free_head;
    lsq_entry_t disp_entry;

    assign head_slot = head[SLOT_W-1:0];
    assign tail_slot = tail[SLOT_W-1:0];

    // same slot, different lap
    assign full       = (head[SLOT_W] != tail[SLOT_W]) && (head_slot == tail_slot);
    assign disp_ready = !full;
    assign disp_slot  = tail_slot;
    assign do_disp    = disp_valid && disp_ready;

    // loads leave once completed, stores once their write is taken
    always_comb begin
        free_head = 1'b0;
        if (entries[head_slot].busy) begin
            if (entries[head_slot].is_load) begin
                free_head = entries[head_slot].comp_sent;
            end else begin
                free_head = sel.drain_fire;
            end
        end
    end

    // fresh entry, address and data come later
    always_comb begin
        disp_entry         = '0;
        disp_entry.busy    = 1'b1;
        disp_entry.is_load = disp_is_load;
        disp_entry.tag     = disp_tag;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                entries[i] <= '0;
            end
            head <= '0;
            tail <= '0;
        end else begin
            // commit only marks stores
            if (commit_valid) begin
                for (int i = 0; i < `LSQ_DEPTH; i++) begin
                    if (entries[i].busy && !entries[i].is_load &&
                        entries[i].tag == commit_tag) begin
                        entries[i].retired <= 1'b1;
                    end
                end
            end
            // execute result lands by slot number
            if (fill_valid) begin
                entries[fill_slot].addr_known <= 1'b1;
                entries[fill_slot].addr       <= fill_addr;
                entries[fill_slot].size       <= fill_size;
                entries[fill_slot].data       <= fill_data;
            end
            if (sel.mem_fire) begin
                entries[sel.mem_slot].mem_sent <= 1'b1;
            end
            // read data overwrites the load's data field
            if (sel.rsp_fire) begin
                entries[sel.rsp_slot].done <= 1'b1;
                entries[sel.rsp_slot].data <= sel.rsp_data;
            end
            if (sel.comp_fire) begin
                entries[sel.comp_slot].comp_sent <= 1'b1;
            end
            if (free_head) begin
                entries[head_slot] <= '0;
                head               <= head + 1'b1;
            end
            // tail never equals a busy head here
            if (do_disp) begin
                entries[tail_slot] <= disp_entry;
                tail               <= tail + 1'b1;
            end
        end
    end

    // pointer logic and head free must agree on slot occupancy
    a_disp_free_slot : assert property (
        @(posedge clock) disable iff (!arst_n)
        do_disp |-> !entries[tail_slot].busy
    );

    // execute unit only fills slots handed out at dispatch
    a_fill_busy : assert property (
        @(posedge clock) disable iff (!arst_n)
        fill_valid |-> entries[fill_slot].busy
    );

endmodule

// File: hdl/lsq_forward.sv
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_forward (
    input  lsq_pkg::lsq_entry_t    entries   [`LSQ_DEPTH],
    input  lsq_pkg::lsq_ptr_t      head,
    output lsq_pkg::lsq_fwd_e      fwd_class [`LSQ_DEPTH],
    output logic [`LSQ_DATA_W-1:0] fwd_data  [`LSQ_DEPTH]
);
    import lsq_pkg::*;

    lsq_slot_t head_slot;

    assign head_slot = head[SLOT_W-1:0];

    always_comb begin
        lsq_slot_t rank_i;
        lsq_slot_t rank_j;
        lsq_slot_t best;
        lsq_slot_t best_rank;
        logic      unknown;
        logic      found;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            // age rank, 0 is the head
            rank_i    = lsq_slot_t'(i) - head_slot;
            unknown   = 1'b0;
            found     = 1'b0;
            best      = '0;
            best_rank = '0;
            for (int j = 0; j < `LSQ_DEPTH; j++) begin
                rank_j = lsq_slot_t'(j) - head_slot;
                // older stores only
                if (entries[j].busy && !entries[j].is_load && rank_j < rank_i) begin
                    if (!entries[j].addr_known) begin
                        unknown = 1'b1;
                    end else if (entries[j].addr.split.word == entries[i].addr.split.word &&
                                 (!found || rank_j > best_rank)) begin
                        // keep the youngest on the same word
                        found     = 1'b1;
                        best      = lsq_slot_t'(j);
                        best_rank = rank_j;
                    end
                end
            end
            fwd_class[i] = FWD_WAIT;
            fwd_data[i]  = entries[best].data;
            if (entries[i].busy && entries[i].is_load && entries[i].addr_known && !unknown) begin
                if (!found) begin
                    fwd_class[i] = FWD_TO_MEMORY;
                end else if (entries[best].addr.raw == entries[i].addr.raw &&
                             entries[best].size == entries[i].size) begin
                    fwd_class[i] = FWD_FORWARD;
                end else begin
                    // partial overlap, wait for the drain
                    fwd_class[i] = FWD_BLOCKED;
                end
            end
        end
    end

endmodule

// File: hdl/lsq_issue.sv
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_issue (
    input  logic                    clock,
    input  logic                    arst_n,
    input  lsq_pkg::lsq_entry_t     entries   [`LSQ_DEPTH],
    input  lsq_pkg::lsq_ptr_t       head,
    input  lsq_pkg::lsq_fwd_e       fwd_class [`LSQ_DEPTH],
    input  logic [`LSQ_DATA_W-1:0]  fwd_data  [`LSQ_DEPTH],
    input  logic                    mem_req_ready,
    input  logic                    mem_rsp_valid,
    input  logic [`LSQ_DATA_W-1:0]  mem_rsp_data,
    input  logic                    comp_ready,
    lsq_sel_if.issue                sel,
    output logic                    mem_req_valid,
    output logic                    mem_req_write,
    output logic [`LSQ_ADDR_W-1:0]  mem_req_addr,
    output lsq_pkg::lsq_size_t      mem_req_size,
    output logic [`LSQ_DATA_W-1:0]  mem_req_data,
    output logic                    comp_valid,
    output logic [`LSQ_TAG_W-1:0]   comp_tag,
    output logic [`LSQ_DATA_W-1:0]  comp_data
);
    import lsq_pkg::*;

    lsq_slot_t head_slot;
    lsq_slot_t ld_pick;
    lsq_slot_t cp_pick;
    lsq_slot_t req_slot;
    lsq_slot_t rd_slot;
    lsq_slot_t comp_slot_q;
    logic      drain_ok;
    logic      ld_ok;
    logic      cp_ok;
    logic      mem_take;
    logic      comp_take;
    logic      rd_out;

    assign head_slot = head[SLOT_W-1:0];
    assign drain_ok  = entries[head_slot].busy && !entries[head_slot].is_load &&
                       entries[head_slot].retired && entries[head_slot].addr_known;

    // walk youngest to oldest so the oldest hit wins
    always_comb begin
        lsq_slot_t s;
        ld_ok   = 1'b0;
        ld_pick = '0;
        cp_ok   = 1'b0;
        cp_pick = '0;
        for (int r = `LSQ_DEPTH - 1; r >= 0; r--) begin
            s = head_slot + lsq_slot_t'(r);
            if (entries[s].busy && entries[s].is_load && !entries[s].comp_sent) begin
                // skip the load already waiting on the completion port
                if (fwd_class[s] == FWD_TO_MEMORY && !entries[s].mem_sent &&
                    !entries[s].done && !(comp_valid && comp_slot_q == s)) begin
                    ld_ok   = 1'b1;
                    ld_pick = s;
                end
                if (entries[s].done || (fwd_class[s] == FWD_FORWARD && !entries[s].mem_sent)) begin
                    cp_ok   = 1'b1;
                    cp_pick = s;
                end
            end
        end
    end

    // new choice only on an idle port
    assign mem_take  = !mem_req_valid && (drain_ok || (ld_ok && !rd_out));
    assign comp_take = !comp_valid && cp_ok;

    assign sel.mem_fire   = mem_req_valid && mem_req_ready && !mem_req_write;
    assign sel.mem_slot   = req_slot;
    assign sel.drain_fire = mem_req_valid && mem_req_ready && mem_req_write;
    assign sel.rsp_fire   = mem_rsp_valid;
    assign sel.rsp_slot   = rd_slot;
    assign sel.rsp_data   = mem_rsp_data;
    assign sel.comp_fire  = comp_valid && comp_ready;
    assign sel.comp_slot  = comp_slot_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_req_valid <= 1'b0;
            comp_valid    <= 1'b0;
            rd_out        <= 1'b0;
        end else begin
            if (mem_take) begin
                mem_req_valid <= 1'b1;
            end else if (mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
            // one read in flight at most
            if (sel.mem_fire) begin
                rd_out <= 1'b1;
            end else if (mem_rsp_valid) begin
                rd_out <= 1'b0;
            end
            if (comp_take) begin
                comp_valid <= 1'b1;
            end else if (comp_ready) begin
                comp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_take) begin
            // retired head store goes first
            if (drain_ok) begin
                mem_req_write <= 1'b1;
                mem_req_addr  <= entries[head_slot].addr.raw;
                mem_req_size  <= entries[head_slot].size;
                mem_req_data  <= entries[head_slot].data;
                req_slot      <= head_slot;
            end else begin
                mem_req_write <= 1'b0;
                mem_req_addr  <= entries[ld_pick].addr.raw;
                mem_req_size  <= entries[ld_pick].size;
                mem_req_data  <= '0;
                req_slot      <= ld_pick;
            end
        end
        // remember where the read data belongs
        if (sel.mem_fire) begin
            rd_slot <= req_slot;
        end
        if (comp_take) begin
            comp_slot_q <= cp_pick;
            comp_tag    <= entries[cp_pick].tag;
            comp_data   <= entries[cp_pick].done ? entries[cp_pick].data : fwd_data[cp_pick];
        end
    end

    a_req_stable : assert property (
        @(posedge clock) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid &&
            $stable({mem_req_write, mem_req_addr, mem_req_size, mem_req_data})
    );

    // memory answers only reads it has taken
    a_rsp_expected : assert property (
        @(posedge clock) disable iff (!arst_n)
        mem_rsp_valid |-> rd_out
    );

endmodule

// File: hdl/lsq_top.sv
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_top (
    input  logic                   clock,
    input  logic                   arst_n,
    // dispatch
    input  logic                   disp_valid,
    output logic                   disp_ready,
    input  logic                   disp_is_load,
    input  logic [`LSQ_TAG_W-1:0]  disp_tag,
    output lsq_pkg::lsq_slot_t     disp_slot,
    // fill from execute
    input  logic                   fill_valid,
    input  lsq_pkg::lsq_slot_t     fill_slot,
    input  logic [`LSQ_ADDR_W-1:0] fill_addr,
    input  lsq_pkg::lsq_size_t     fill_size,
    input  logic [`LSQ_DATA_W-1:0] fill_data,
    // commit
    input  logic                   commit_valid,
    input  logic [`LSQ_TAG_W-1:0]  commit_tag,
    // memory port
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    output logic                   mem_req_write,
    output logic [`LSQ_ADDR_W-1:0] mem_req_addr,
    output lsq_pkg::lsq_size_t     mem_req_size,
    output logic [`LSQ_DATA_W-1:0] mem_req_data,
    input  logic                   mem_rsp_valid,
    input  logic [`LSQ_DATA_W-1:0] mem_rsp_data,
    // completion
    output logic                   comp_valid,
    input  logic                   comp_ready,
    output logic [`LSQ_TAG_W-1:0]  comp_tag,
    output logic [`LSQ_DATA_W-1:0] comp_data
);
    import lsq_pkg::*;

    lsq_entry_t             entries   [`LSQ_DEPTH];
    lsq_ptr_t               head;
    lsq_fwd_e               fwd_class [`LSQ_DEPTH];
    logic [`LSQ_DATA_W-1:0] fwd_data  [`LSQ_DEPTH];

    lsq_sel_if sel_if ();

    lsq_queue u_queue (
        .clock        (clock),
        .arst_n       (arst_n),
        .disp_valid   (disp_valid),
        .disp_is_load (disp_is_load),
        .disp_tag     (disp_tag),
        .fill_valid   (fill_valid),
        .fill_slot    (fill_slot),
        .fill_addr    (fill_addr),
        .fill_size    (fill_size),
        .fill_data    (fill_data),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .sel          (sel_if.queue),
        .disp_ready   (disp_ready),
        .disp_slot    (disp_slot),
        .entries      (entries),
        .head         (head)
    );

    lsq_forward u_forward (
        .entries   (entries),
        .head      (head),
        .fwd_class (fwd_class),
        .fwd_data  (fwd_data)
    );

    lsq_issue u_issue (
        .clock         (clock),
        .arst_n        (arst_n),
        .entries       (entries),
        .head          (head),
        .fwd_class     (fwd_class),
        .fwd_data      (fwd_data),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .comp_ready    (comp_ready),
        .sel           (sel_if.issue),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_size  (mem_req_size),
        .mem_req_data  (mem_req_data),
        .comp_valid    (comp_valid),
        .comp_tag      (comp_tag),
        .comp_data     (comp_data)
    );

endmodule

// File: tb/tb_lsq.sv
`timescale 1ns/1ps
`include "lsq_defines.svh"

module tb_lsq;
    import lsq_pkg::*;

    localparam int TIMEOUT = 200;

    typedef enum {OP_ST, OP_LDF, OP_LD, OP_LDB, OP_CM, OP_WT} op_e;

    typedef struct {
        string       name;
        op_e         op;
        logic [5:0]  tag;
        logic [31:0] addr;
        lsq_size_t   size;
        logic [31:0] data;
        logic [31:0] exp;
        logic        exp_mem;
    } row_t;

    logic                   clock;
    logic                   arst_n;
    logic                   disp_valid;
    logic                   disp_ready;
    logic                   disp_is_load;
    logic [`LSQ_TAG_W-1:0]  disp_tag;
    lsq_slot_t              disp_slot;
    logic                   fill_valid;
    lsq_slot_t              fill_slot;
    logic [`LSQ_ADDR_W-1:0] fill_addr;
    lsq_size_t              fill_size;
    logic [`LSQ_DATA_W-1:0] fill_data;
    logic                   commit_valid;
    logic [`LSQ_TAG_W-1:0]  commit_tag;
    logic                   mem_req_valid;
    logic                   mem_req_ready;
    logic                   mem_req_write;
    logic [`LSQ_ADDR_W-1:0] mem_req_addr;
    lsq_size_t              mem_req_size;
    logic [`LSQ_DATA_W-1:0] mem_req_data;
    logic                   mem_rsp_valid;
    logic [`LSQ_DATA_W-1:0] mem_rsp_data;
    logic                   comp_valid;
    logic                   comp_ready;
    logic [`LSQ_TAG_W-1:0]  comp_tag;
    logic [`LSQ_DATA_W-1:0] comp_data;

    // memory model contents and the testbench's own prediction
    logic [31:0] model_mem [256];
    logic [31:0] ref_mem   [256];
    logic [31:0] lcg_state;
    logic [31:0] rnd;
    int          writes_seen;
    int          reads_seen;
    logic [31:0] last_wr_addr;
    lsq_size_t   last_wr_size;
    logic [31:0] last_wr_data;
    // word that must not be read while set
    logic        guard_valid;
    logic [28:0] guard_word;
    row_t        rows [$];

    lsq_top dut (.*);

    always #4 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // place store data into its byte lanes of a 32-bit word
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] addr,
                                          input lsq_size_t size, input logic [31:0] data);
        logic [31:0] w;
        w = old;
        if (size == SZ_BYTE) begin
            w[8*addr[1:0] +: 8] = data[7:0];
        end else if (size == SZ_HALF) begin
            w[16*addr[1] +: 16] = data[15:0];
        end else begin
            w = data;
        end
        return w;
    endfunction

    task automatic die(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            die($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    // a load row says whether it needed a memory read
    task automatic check_read(input row_t r, input int reads_before);
        check_value({r.name, "_mem_read"}, 32'(r.exp_mem), 32'(reads_seen != reads_before));
    endtask

    task automatic add_row(input string name, input op_e op, input logic [5:0] tag,
                           input logic [31:0] addr, input lsq_size_t size,
                           input logic [31:0] data, input logic [31:0] exp,
                           input logic exp_mem);
        row_t r;
        r.name    = name;
        r.op      = op;
        r.tag     = tag;
        r.addr    = addr;
        r.size    = size;
        r.data    = data;
        r.exp     = exp;
        r.exp_mem = exp_mem;
        rows.push_back(r);
    endtask

    // memory: random stalls, read data one cycle after acceptance
    always @(posedge clock) begin
        rnd = lcg_next();
        mem_req_ready <= !rnd[0];
        mem_rsp_valid <= 1'b0;
        if (arst_n && mem_req_valid && mem_req_ready) begin
            if (mem_req_write) begin
                model_mem[mem_req_addr[9:2]] <= merge(model_mem[mem_req_addr[9:2]],
                                                      mem_req_addr, mem_req_size, mem_req_data);
                writes_seen  <= writes_seen + 1;
                last_wr_addr <= mem_req_addr;
                last_wr_size <= mem_req_size;
                last_wr_data <= mem_req_data;
            end else begin
                assert (!(guard_valid && mem_req_addr[31:3] == guard_word)) else begin
                    die($sformatf("read of address %h issued while an older store covers it",
                                  mem_req_addr));
                end
                reads_seen    <= reads_seen + 1;
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= model_mem[mem_req_addr[9:2]];
            end
        end
    end

    task automatic dispatch_fill(input row_t r, input logic is_load);
        int        n;
        lsq_slot_t slot;
        disp_valid   <= 1'b1;
        disp_is_load <= is_load;
        disp_tag     <= r.tag;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clock);
            if (disp_ready) break;
        end
        if (n == TIMEOUT) die($sformatf("timeout: %s was never accepted at dispatch", r.name));
        slot = disp_slot;
        disp_valid <= 1'b0;
        fill_valid <= 1'b1;
        fill_slot  <= slot;
        fill_addr  <= r.addr;
        fill_size  <= r.size;
        fill_data  <= r.data;
        @(posedge clock);
        fill_valid <= 1'b0;
    endtask

    task automatic wait_completion(input string name, input logic [5:0] tag,
                                   input logic [31:0] exp);
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clock);
            if (comp_valid && comp_ready) break;
        end
        if (n == TIMEOUT) die($sformatf("timeout: no completion for %s", name));
        check_value({name, "_tag"}, 32'(tag), 32'(comp_tag));
        check_value(name, exp, comp_data);
    endtask

    task automatic commit_store(input row_t r, input int done_before);
        int n;
        // nothing may drain before its commit
        check_value({r.name, "_no_early_write"}, done_before, writes_seen);
        commit_valid <= 1'b1;
        commit_tag   <= r.tag;
        @(posedge clock);
        commit_valid <= 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clock);
            if (writes_seen == done_before + 1) break;
        end
        if (n == TIMEOUT) die($sformatf("timeout: store of %s never written", r.name));
        check_value({r.name, "_addr"}, r.addr, last_wr_addr);
        check_value({r.name, "_size"}, 32'(r.size), 32'(last_wr_size));
        check_value({r.name, "_data"}, r.data, last_wr_data);
        ref_mem[r.addr[9:2]] = merge(ref_mem[r.addr[9:2]], r.addr, r.size, r.data);
        guard_valid = 1'b0;
    endtask

    initial begin
        int          commits;
        int          n;
        int          reads_before;
        logic [5:0]  held_tag;
        logic [31:0] held_data;
        row_t        r;
        clock = 1'b0;
        arst_n = 1'b0;
        disp_valid = 1'b0;
        disp_is_load = 1'b0;
        disp_tag = '0;
        fill_valid = 1'b0;
        fill_slot = '0;
        fill_addr = '0;
        fill_size = SZ_WORD;
        fill_data = '0;
        commit_valid = 1'b0;
        commit_tag = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        comp_ready = 1'b1;
        writes_seen = 0;
        reads_seen = 0;
        reads_before = 0;
        guard_valid = 1'b0;
        guard_word = '0;
        commits = 0;
        lcg_state = 32'h2899_50ef;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = lcg_next();
            ref_mem[i]   = model_mem[i];
        end

        // forwarding, miss, drain, partial overlap
        add_row("fwd_st",  OP_ST,  6'd1,  32'h40,  SZ_WORD, 32'hcafe_0001, '0, 1'b0);
        add_row("fwd_ld",  OP_LDF, 6'd2,  32'h40,  SZ_WORD, '0, 32'hcafe_0001, 1'b0);
        add_row("fwd_cm",  OP_CM,  6'd1,  32'h40,  SZ_WORD, 32'hcafe_0001, '0, 1'b0);
        add_row("miss_ld", OP_LD,  6'd3,  32'h88,  SZ_WORD, '0, '0, 1'b1);
        add_row("drn_st",  OP_ST,  6'd4,  32'h100, SZ_WORD, 32'h1234_5678, '0, 1'b0);
        add_row("drn_cm",  OP_CM,  6'd4,  32'h100, SZ_WORD, 32'h1234_5678, '0, 1'b0);
        add_row("drn_ld",  OP_LD,  6'd5,  32'h100, SZ_WORD, '0, '0, 1'b1);
        add_row("par_st",  OP_ST,  6'd10, 32'h181, SZ_BYTE, 32'h0000_00a5, '0, 1'b0);
        add_row("par_ld",  OP_LDB, 6'd11, 32'h180, SZ_WORD, '0, '0, 1'b1);
        add_row("par_cm",  OP_CM,  6'd10, 32'h181, SZ_BYTE, 32'h0000_00a5, '0, 1'b0);
        add_row("par_wt",  OP_WT,  6'd11, 32'h180, SZ_WORD, '0, '0, 1'b1);

        repeat (10) @(posedge clock);
        arst_n <= 1'b1;
        @(posedge clock);
        check_value("reset_disp_ready", 1, disp_ready);
        check_value("reset_mem_req_valid", 0, mem_req_valid);
        check_value("reset_comp_valid", 0, comp_valid);

        foreach (rows[k]) begin
            r = rows[k];
            case (r.op)
                OP_ST:  dispatch_fill(r, 1'b0);
                OP_LDF: begin
                    guard_word   = r.addr[31:3];
                    guard_valid  = 1'b1;
                    reads_before = reads_seen;
                    dispatch_fill(r, 1'b1);
                    wait_completion(r.name, r.tag, r.exp);
                    check_read(r, reads_before);
                    guard_valid = 1'b0;
                end
                OP_LD: begin
                    reads_before = reads_seen;
                    dispatch_fill(r, 1'b1);
                    wait_completion(r.name, r.tag, ref_mem[r.addr[9:2]]);
                    check_read(r, reads_before);
                end
                // blocked load, the guard stays until the store is written
                OP_LDB: begin
                    guard_word   = r.addr[31:3];
                    guard_valid  = 1'b1;
                    reads_before = reads_seen;
                    dispatch_fill(r, 1'b1);
                    repeat (6) @(posedge clock);
                end
                OP_CM: begin
                    commit_store(r, commits);
                    commits++;
                end
                default: begin
                    wait_completion(r.name, r.tag, ref_mem[r.addr[9:2]]);
                    check_read(r, reads_before);
                end
            endcase
        end

        // fill all eight slots while completions are stalled
        comp_ready <= 1'b0;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            r.name = $sformatf("full_ld%0d", i);
            r.tag  = 6'(20 + i);
            r.addr = 32'h200 + 32'(8 * i);
            r.size = SZ_WORD;
            r.data = '0;
            dispatch_fill(r, 1'b1);
        end
        check_value("full_disp_ready", 0, disp_ready);
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clock);
            if (comp_valid) break;
        end
        if (n == TIMEOUT) die("timeout: no completion offered while stalled");
        held_tag  = comp_tag;
        held_data = comp_data;
        repeat (16) begin
            @(posedge clock);
            check_value("hold_valid", 1, comp_valid);
            check_value("hold_tag", 32'(held_tag), 32'(comp_tag));
            check_value("hold_data", held_data, comp_data);
        end
        comp_ready <= 1'b1;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            wait_completion($sformatf("full_ld%0d", i), 6'(20 + i),
                            ref_mem[(32'h200 + 32'(8 * i)) >> 2]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/lsq_pkg.sv
hdl/lsq_sel_if.sv
hdl/lsq_queue.sv
hdl/lsq_forward.sv
hdl/lsq_issue.sv
hdl/lsq_top.sv
tb/tb_lsq.sv

// File: run.sh
#!/bin/sh
# build and run the load/store queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
( verilator --binary --timing --assert -f tb.f --top-module tb_lsq -o tb_lsq \
    && ./obj_dir/tb_lsq ) > sim.log 2>&1 \
    || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
